// ==== hw/cgra_pkg.sv ====
package cgra_pkg;

	// tracks per side and sides per tile.
	localparam int TRACKS = 4;
	localparam int SIDES = 4;

	// side order inside a tile bundle.
	localparam int SIDE_NORTH = 0;
	localparam int SIDE_EAST = 1;
	localparam int SIDE_SOUTH = 2;
	localparam int SIDE_WEST = 3;

	typedef logic [TRACKS-1:0] track_t;
	typedef track_t [SIDES-1:0] side_tracks_t;

	typedef logic [15:0] blk_t;

	localparam blk_t BLK_SB = 16'd7;
	localparam blk_t BLK_CB0 = 16'd6;
	localparam blk_t BLK_CB1 = 16'd5;
	localparam blk_t BLK_CLB = 16'd4;

	typedef struct packed {
		blk_t blk;
		logic [15:0] tile_id;
	} cfg_addr_t;

	// route code of one switch box output track.
	typedef enum logic [1:0] {
		SB_ZERO = 2'd0,
		SB_OPPOSITE = 2'd1,
		SB_PE = 2'd2,
		SB_CW_NEXT = 2'd3
	} sb_sel_t;

	typedef enum logic [1:0] {
		CLB_AND = 2'd0,
		CLB_OR = 2'd1,
		CLB_XOR = 2'd2,
		CLB_PASS_A = 2'd3
	} clb_op_t;

	// connect box and logic block share this layout.
	typedef struct packed {
		logic [28:0] pad;
		logic [2:0] sel;
	} cfg_blk_t;

	// sb index is side * TRACKS + track.
	typedef union packed {
		sb_sel_t [SIDES*TRACKS-1:0] sb;
		cfg_blk_t blk;
	} cfg_data_u;

	typedef struct packed {
		logic valid;
		cfg_addr_t addr;
		cfg_data_u data;
	} cfg_req_t;

endpackage

// ==== hw/connect_box.sv ====
`timescale 1ns/1ps

module connect_box import cgra_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic config_en,
	input cfg_data_u sel_data,
	input track_t side_in,
	input track_t side_out,
	output logic block_in
);

	logic [2:0] sel_q;
	logic [2*TRACKS-1:0] choices;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= sel_data.blk.sel;
		end
	end

	// inputs are choices 0 to 3, outputs 4 to 7.
	assign choices = {side_out, side_in};

	assign block_in = choices[sel_q];

endmodule

// ==== hw/switch_box.sv ====
`timescale 1ns/1ps

module switch_box import cgra_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic config_en,
	input cfg_data_u config_data,
	input side_tracks_t in_tracks,
	input logic pe_result,
	output side_tracks_t out_tracks
);

	cfg_data_u route_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			route_q <= '0;
		end else if (config_en) begin
			route_q <= config_data;
		end
	end

	// one mux per output track.
	for (genvar s = 0; s < SIDES; s++) begin : g_side
		localparam int OPP = (s + 2) % SIDES;
		localparam int CW = (s + 1) % SIDES;

		for (genvar t = 0; t < TRACKS; t++) begin : g_track
			sb_sel_t code;

			assign code = route_q.sb[s*TRACKS+t];

			always_comb begin
				case (code)
					SB_OPPOSITE: begin
						out_tracks[s][t] = in_tracks[OPP][t];
					end
					SB_PE: begin
						out_tracks[s][t] = pe_result;
					end
					SB_CW_NEXT: begin
						// same track, next side clockwise.
						out_tracks[s][t] = in_tracks[CW][t];
					end
					default: begin
						out_tracks[s][t] = 1'b0;
					end
				endcase
			end
		end
	end

endmodule

// ==== hw/logic_block.sv ====
`timescale 1ns/1ps

module logic_block import cgra_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic config_en,
	input cfg_data_u config_data,
	input logic op_a,
	input logic op_b,
	output logic result
);

	clb_op_t op_q;
	logic result_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= CLB_AND;
		end else if (config_en) begin
			op_q <= clb_op_t'(config_data.blk.sel[1:0]);
		end
	end

	always_comb begin
		case (op_q)
			CLB_AND: result_d = op_a & op_b;
			CLB_OR: result_d = op_a | op_b;
			CLB_XOR: result_d = op_a ^ op_b;
			default: result_d = op_a;
		endcase
	end

	// result lags its operands by one clock.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= 1'b0;
		end else begin
			result <= result_d;
		end
	end

endmodule

// ==== hw/pe_tile.sv ====
`timescale 1ns/1ps

module pe_tile import cgra_pkg::*; #(
	parameter int TILE_ID = 0
) (
	input logic clk,
	input logic arst_n,
	input cfg_req_t cfg,
	input side_tracks_t in_tracks,
	output side_tracks_t out_tracks
);

	logic tile_hit;
	logic config_en_sb;
	logic config_en_cb0;
	logic config_en_cb1;
	logic config_en_clb;
	logic op_0;
	logic op_1;
	logic pe_output;

	assign tile_hit = cfg.valid && (cfg.addr.tile_id == 16'(TILE_ID));

	// unknown block codes raise no enable and are dropped.
	always_comb begin
		config_en_sb = 1'b0;
		config_en_cb0 = 1'b0;
		config_en_cb1 = 1'b0;
		config_en_clb = 1'b0;
		if (tile_hit) begin
			case (cfg.addr.blk)
				BLK_SB: config_en_sb = 1'b1;
				BLK_CB0: config_en_cb0 = 1'b1;
				BLK_CB1: config_en_cb1 = 1'b1;
				BLK_CLB: config_en_clb = 1'b1;
				default: begin
				end
			endcase
		end
	end

	// first operand comes from the north side.
	connect_box cb0 (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(config_en_cb0),
		.sel_data(cfg.data),
		.side_in(in_tracks[SIDE_NORTH]),
		.side_out(out_tracks[SIDE_NORTH]),
		.block_in(op_0)
	);

	// second operand comes from the east side.
	connect_box cb1 (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(config_en_cb1),
		.sel_data(cfg.data),
		.side_in(in_tracks[SIDE_EAST]),
		.side_out(out_tracks[SIDE_EAST]),
		.block_in(op_1)
	);

	switch_box sb (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(config_en_sb),
		.config_data(cfg.data),
		.in_tracks(in_tracks),
		.pe_result(pe_output),
		.out_tracks(out_tracks)
	);

	logic_block compute_block (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(config_en_clb),
		.config_data(cfg.data),
		.op_a(op_0),
		.op_b(op_1),
		.result(pe_output)
	);

endmodule

// ==== hw/cgra_fabric.sv ====
`timescale 1ns/1ps

module cgra_fabric import cgra_pkg::*; #(
	parameter int ROWS = 2,
	parameter int COLS = 2
) (
	input logic clk,
	input logic arst_n,
	input cfg_req_t cfg,
	input track_t [COLS-1:0] edge_in_north,
	input track_t [COLS-1:0] edge_in_south,
	input track_t [ROWS-1:0] edge_in_east,
	input track_t [ROWS-1:0] edge_in_west,
	output track_t [COLS-1:0] edge_out_north,
	output track_t [COLS-1:0] edge_out_south,
	output track_t [ROWS-1:0] edge_out_east,
	output track_t [ROWS-1:0] edge_out_west
);

	// row 0 is the north row, column 0 the west column.
	wire side_tracks_t tile_in [ROWS][COLS];
	wire side_tracks_t tile_out [ROWS][COLS];

	for (genvar r = 0; r < ROWS; r++) begin : g_row
		for (genvar c = 0; c < COLS; c++) begin : g_col

			pe_tile #(
				.TILE_ID(r * COLS + c)
			) u_tile (
				.clk(clk),
				.arst_n(arst_n),
				.cfg(cfg),
				.in_tracks(tile_in[r][c]),
				.out_tracks(tile_out[r][c])
			);

			if (r == 0) begin : g_north_edge
				assign tile_in[r][c][SIDE_NORTH] = edge_in_north[c];
				assign edge_out_north[c] = tile_out[r][c][SIDE_NORTH];
			end else begin : g_north_link
				assign tile_in[r][c][SIDE_NORTH] = tile_out[r-1][c][SIDE_SOUTH];
			end

			if (r == ROWS - 1) begin : g_south_edge
				assign tile_in[r][c][SIDE_SOUTH] = edge_in_south[c];
				assign edge_out_south[c] = tile_out[r][c][SIDE_SOUTH];
			end else begin : g_south_link
				assign tile_in[r][c][SIDE_SOUTH] = tile_out[r+1][c][SIDE_NORTH];
			end

			if (c == 0) begin : g_west_edge
				assign tile_in[r][c][SIDE_WEST] = edge_in_west[r];
				assign edge_out_west[r] = tile_out[r][c][SIDE_WEST];
			end else begin : g_west_link
				assign tile_in[r][c][SIDE_WEST] = tile_out[r][c-1][SIDE_EAST];
			end

			if (c == COLS - 1) begin : g_east_edge
				assign tile_in[r][c][SIDE_EAST] = edge_in_east[r];
				assign edge_out_east[r] = tile_out[r][c][SIDE_EAST];
			end else begin : g_east_link
				assign tile_in[r][c][SIDE_EAST] = tile_out[r][c+1][SIDE_WEST];
			end

		end
	end

endmodule

// ==== sim/pe_tile_assertions.sv ====
`timescale 1ns/1ps

module pe_tile_assertions import cgra_pkg::*; (
	input logic clk,
	input logic arst_n,
	input cfg_req_t cfg,
	input logic en_sb,
	input logic en_cb0,
	input logic en_cb1,
	input logic en_clb,
	input side_tracks_t out_tracks
);

	logic [3:0] enables;

	assign enables = {en_sb, en_cb0, en_cb1, en_clb};

	a_one_enable: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(enables))
		else $error("more than one block enable high");

	// enables only follow a valid request.
	a_no_enable_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!cfg.valid |-> enables == 4'b0000)
		else $error("block enable high without a valid request");

	a_tracks_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(out_tracks))
		else $error("out_tracks has unknown bits");

endmodule

bind pe_tile pe_tile_assertions i_assertions (
	.clk(clk),
	.arst_n(arst_n),
	.cfg(cfg),
	.en_sb(config_en_sb),
	.en_cb0(config_en_cb0),
	.en_cb1(config_en_cb1),
	.en_clb(config_en_clb),
	.out_tracks(out_tracks)
);

// ==== sim/tb_cgra.sv ====
`timescale 1ns/1ps

module tb_cgra import cgra_pkg::*;;

	localparam int ROWS = 2;
	localparam int COLS = 2;
	localparam int NT = ROWS * COLS;
	localparam int RESET_CYCLES = 8;
	localparam int RUN_LEN = 30;
	localparam int MAX_WRITES = 40;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 9 * RUN_LEN + 2 * MAX_WRITES;
	localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * 8;

	logic clk = 1'b0;
	logic arst_n;
	cfg_req_t cfg;
	track_t [COLS-1:0] edge_in_north;
	track_t [COLS-1:0] edge_in_south;
	track_t [ROWS-1:0] edge_in_east;
	track_t [ROWS-1:0] edge_in_west;
	track_t [COLS-1:0] edge_out_north;
	track_t [COLS-1:0] edge_out_south;
	track_t [ROWS-1:0] edge_out_east;
	track_t [ROWS-1:0] edge_out_west;

	// shadow of the fabric state.
	logic [1:0] m_route [NT][SIDES*TRACKS];
	logic [2:0] m_cb0 [NT];
	logic [2:0] m_cb1 [NT];
	logic [1:0] m_op [NT];
	logic m_res [NT];
	side_tracks_t m_in [NT];
	side_tracks_t m_out [NT];

	logic [31:0] lfsr = 32'd83836;
	int errors = 0;
	int pass_count = 0;
	int fail_count = 0;

	cgra_fabric #(.ROWS(ROWS), .COLS(COLS)) i_dut (.*);

	always #4 clk = ~clk;

	function automatic logic lfsr_step();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'hA300_0000;
		return b;
	endfunction

	function automatic logic [7:0] rand_bits(int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v[i] = lfsr_step();
		return v;
	endfunction

	function automatic logic [31:0] set_route(logic [31:0] w, int s, int t, logic [1:0] code);
		logic [31:0] r;
		r = w;
		r[2*(s*TRACKS+t) +: 2] = code;
		return r;
	endfunction

	function automatic logic [31:0] side_route(logic [31:0] w, int s, logic [1:0] code);
		logic [31:0] r;
		r = w;
		for (int t = 0; t < TRACKS; t++) r = set_route(r, s, t, code);
		return r;
	endfunction

	function automatic logic pick(track_t tin, track_t tout, logic [2:0] sel);
		logic [7:0] ch;
		ch = {tout, tin};
		return ch[sel];
	endfunction

	function automatic logic apply_op(logic [1:0] op, logic a, logic b);
		case (op)
			2'd0: return a & b;
			2'd1: return a | b;
			2'd2: return a ^ b;
			default: return a;
		endcase
	endfunction

	// sweeps the grid once per tile so every loop-free path settles.
	function automatic void eval_tracks();
		int id;
		for (int i = 0; i < NT; i++) m_out[i] = '0;
		repeat (NT) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < COLS; c++) begin
					id = r * COLS + c;
					m_in[id][0] = (r == 0) ? edge_in_north[c] : m_out[id-COLS][2];
					m_in[id][2] = (r == ROWS - 1) ? edge_in_south[c] : m_out[id+COLS][0];
					m_in[id][3] = (c == 0) ? edge_in_west[r] : m_out[id-1][1];
					m_in[id][1] = (c == COLS - 1) ? edge_in_east[r] : m_out[id+1][3];
					for (int s = 0; s < SIDES; s++) begin
						for (int t = 0; t < TRACKS; t++) begin
							case (m_route[id][s*TRACKS+t])
								2'd1: m_out[id][s][t] = m_in[id][(s+2)%SIDES][t];
								2'd2: m_out[id][s][t] = m_res[id];
								2'd3: m_out[id][s][t] = m_in[id][(s+1)%SIDES][t];
								default: m_out[id][s][t] = 1'b0;
							endcase
						end
					end
				end
			end
		end
	endfunction

	task automatic check_hex(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// compare, then advance results and apply the write on the bus.
	always @(negedge clk) begin : model_step
		logic nres [NT];
		int id;
		if (!arst_n) begin
			for (int i = 0; i < NT; i++) begin
				for (int k = 0; k < SIDES*TRACKS; k++) m_route[i][k] = 2'd0;
				m_cb0[i] = 3'd0;
				m_cb1[i] = 3'd0;
				m_op[i] = 2'd0;
				m_res[i] = 1'b0;
			end
		end else begin
			eval_tracks();
			for (int c = 0; c < COLS; c++) begin
				check_hex("edge_out_north", 32'(m_out[c][0]), 32'(edge_out_north[c]));
				check_hex("edge_out_south", 32'(m_out[(ROWS-1)*COLS+c][2]),
					32'(edge_out_south[c]));
			end
			for (int r = 0; r < ROWS; r++) begin
				check_hex("edge_out_west", 32'(m_out[r*COLS][3]), 32'(edge_out_west[r]));
				check_hex("edge_out_east", 32'(m_out[r*COLS+COLS-1][1]),
					32'(edge_out_east[r]));
			end
			for (int i = 0; i < NT; i++) begin
				nres[i] = apply_op(m_op[i], pick(m_in[i][0], m_out[i][0], m_cb0[i]),
					pick(m_in[i][1], m_out[i][1], m_cb1[i]));
			end
			if (cfg.valid && cfg.addr.tile_id < 16'(NT)) begin
				id = int'(cfg.addr.tile_id);
				case (cfg.addr.blk)
					16'd7: begin
						for (int k = 0; k < SIDES*TRACKS; k++) begin
							m_route[id][k] = cfg.data[2*k +: 2];
						end
					end
					16'd6: m_cb0[id] = cfg.data[2:0];
					16'd5: m_cb1[id] = cfg.data[2:0];
					16'd4: m_op[id] = cfg.data[1:0];
					default: ;
				endcase
			end
			for (int i = 0; i < NT; i++) m_res[i] = nres[i];
		end
	end

	task automatic drive_edges();
		@(posedge clk);
		edge_in_north <= rand_bits(8);
		edge_in_south <= rand_bits(8);
		edge_in_east <= rand_bits(8);
		edge_in_west <= rand_bits(8);
	endtask

	task automatic write_cfg(int tile, logic [15:0] blk, logic [31:0] data);
		cfg_req_t req;
		req.valid = 1'b1;
		req.addr.blk = blk;
		req.addr.tile_id = 16'(tile);
		req.data = data;
		@(posedge clk);
		cfg <= req;
		@(posedge clk);
		cfg.valid <= 1'b0;
	endtask

	task automatic finish_test(string name, int err_before);
		if (errors == err_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS * 1ns);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin : tests
		int e0;
		logic [31:0] w;
		logic h1;
		logic h2;
		arst_n = 1'b0;
		cfg = '0;
		edge_in_north = '0;
		edge_in_south = '0;
		edge_in_east = '0;
		edge_in_west = '0;
		h1 = 1'b0;
		h2 = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		e0 = errors;
		for (int i = 0; i < RUN_LEN; i++) begin
			drive_edges();
			@(negedge clk);
			check_hex("edge_out_north", 32'h0, 32'(edge_out_north));
			check_hex("edge_out_south", 32'h0, 32'(edge_out_south));
			check_hex("edge_out_east", 32'h0, 32'(edge_out_east));
			check_hex("edge_out_west", 32'h0, 32'(edge_out_west));
		end
		finish_test("reset_zero", e0);

		e0 = errors;
		w = side_route(side_route(32'h0, SIDE_EAST, 2'd1), SIDE_SOUTH, 2'd1);
		for (int i = 0; i < NT; i++) write_cfg(i, BLK_SB, w);
		for (int i = 0; i < RUN_LEN; i++) begin
			drive_edges();
			@(negedge clk);
			check_hex("edge_out_east", 32'(edge_in_west), 32'(edge_out_east));
			check_hex("edge_out_south", 32'(edge_in_north), 32'(edge_out_south));
		end
		finish_test("straight_route", e0);

		e0 = errors;
		// tile 1 turns the east edge back west so both operands carry data.
		w = side_route(side_route(32'h0, SIDE_EAST, 2'd1), SIDE_WEST, 2'd1);
		write_cfg(1, BLK_SB, side_route(w, SIDE_SOUTH, 2'd1));
		w = side_route(side_route(32'h0, SIDE_WEST, 2'd2), SIDE_NORTH, 2'd3);
		write_cfg(0, BLK_SB, side_route(w, SIDE_EAST, 2'd1));
		for (int op = 0; op < 4; op++) begin
			write_cfg(0, BLK_CB0, 32'(rand_bits(3)));
			write_cfg(0, BLK_CB1, 32'(rand_bits(3)));
			write_cfg(0, BLK_CLB, 32'(op));
			repeat (RUN_LEN / 2) drive_edges();
		end
		finish_test("logic_ops", e0);

		e0 = errors;
		write_cfg(9, BLK_SB, 32'hFFFF_FFFF);
		write_cfg(0, 16'd3, 32'hFFFF_FFFE);
		write_cfg(2, 16'd8, 32'(rand_bits(8)));
		repeat (RUN_LEN) drive_edges();
		finish_test("ignored_writes", e0);

		e0 = errors;
		write_cfg(0, BLK_CB0, 32'd0);
		write_cfg(0, BLK_CLB, 32'd3);
		write_cfg(0, BLK_SB, set_route(32'h0, SIDE_EAST, 0, 2'd2));
		write_cfg(1, BLK_CB0, 32'd5);
		write_cfg(1, BLK_CB1, 32'd4);
		write_cfg(1, BLK_CLB, 32'd1);
		w = set_route(32'h0, SIDE_EAST, 0, 2'd1);
		write_cfg(1, BLK_SB, set_route(w, SIDE_NORTH, 0, 2'd2));
		for (int i = 0; i < RUN_LEN; i++) begin
			drive_edges();
			@(negedge clk);
			if (i >= 2) begin
				check_hex("edge_out_north[1][0]", 32'(h2), 32'(edge_out_north[1][0]));
			end
			h2 = h1;
			h1 = edge_in_north[0][0];
		end
		finish_test("two_tile_chain", e0);

		e0 = errors;
		write_cfg(0, BLK_SB, side_route(32'h0, SIDE_WEST, 2'd3));
		write_cfg(3, BLK_SB, side_route(32'h0, SIDE_EAST, 2'd3));
		for (int i = 0; i < RUN_LEN; i++) begin
			drive_edges();
			@(negedge clk);
			check_hex("edge_out_west[0]", 32'(edge_in_north[0]), 32'(edge_out_west[0]));
			check_hex("edge_out_east[1]", 32'(edge_in_south[1]), 32'(edge_out_east[1]));
		end
		finish_test("corner_route", e0);

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/cgra_pkg.sv
hw/connect_box.sv
hw/switch_box.sv
hw/logic_block.sv
hw/pe_tile.sv
hw/cgra_fabric.sv
sim/pe_tile_assertions.sv
sim/tb_cgra.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_cgra
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
